/* vlog.f */
rtl/corr_pkg.sv
rtl/integration_timer.sv
rtl/pulse_counter.sv
rtl/baseline_accumulator.sv
rtl/readout_sequencer.sv
rtl/correlator_top.sv
verification/correlator_properties.sv
verification/correlator_tb.sv

/* Makefile */
# Verilator build and run for the correlator front end

VERILATOR ?= verilator
TOP ?= correlator_tb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_EXE)
	-$(SIM_EXE) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/correlator_tb.sv */
// correlator testbench
// random, saturating and enable-drop integrations with xorshift samples
module correlator_tb;

	logic clk;
	logic reset;
	logic enable;
	logic sample_valid;
	corr_pkg::sample_frame_t samples;
	logic [corr_pkg::len_width-1:0] integration_len;
	logic record_valid;
	corr_pkg::record_t record;
	logic [31:0] rng_state;

	correlator_top UUT (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.sample_valid(sample_valid),
		.samples(samples),
		.integration_len(integration_len),
		.record_valid(record_valid),
		.record(record)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// stop at the first failed assertion
	always @(negedge clk) begin
		if (UUT.prop_check.failed) begin
			$display("ERRORS FOUND");
			$fatal(1, "the bound checker flagged a wrong record");
		end
	end

	task automatic idle_cycles(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			sample_valid <= 1'b0;
		end
	endtask

	task automatic drive_samples(input int count, input bit all_max, input bit with_gaps);
		int sent;
		int cycles;
		sent = 0;
		cycles = 0;
		while (sent < count) begin
			@(posedge clk);
			rng_state = xorshift(rng_state);
			cycles++;
			if (cycles > 8 * count + 100) begin
				$display("ERRORS FOUND");
				$fatal(1, "sample stream stalled after %0d of %0d samples", sent, count);
			end
			if (with_gaps && rng_state[31:30] == 2'b00) begin
				sample_valid <= 1'b0; // gap
			end else begin
				sample_valid <= 1'b1;
				samples <= all_max ? 8'hff : rng_state[7:0];
				sent++;
			end
		end
		@(posedge clk);
		sample_valid <= 1'b0;
	endtask

	task automatic wait_for_burst();
		int waited;
		waited = 0;
		while (!record_valid) begin
			@(negedge clk);
			waited++;
			if (waited > 20) begin
				$display("ERRORS FOUND");
				$fatal(1, "no record burst after the final sample of the window");
			end
		end
		waited = 0;
		while (record_valid) begin
			@(negedge clk);
			waited++;
			if (waited > 2 * corr_pkg::num_records) begin
				$display("ERRORS FOUND");
				$fatal(1, "record burst did not end");
			end
		end
	endtask

	task automatic run_integration(input int len, input bit all_max, input bit with_gaps);
		@(posedge clk);
		integration_len <= 16'(len);
		drive_samples(len, all_max, with_gaps);
		wait_for_burst();
	endtask

	// strobes while disabled must be ignored
	task automatic drop_enable(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			rng_state = xorshift(rng_state);
			enable <= 1'b0;
			sample_valid <= 1'b1;
			samples <= rng_state[7:0];
		end
		@(posedge clk);
		enable <= 1'b1;
		sample_valid <= 1'b0;
	endtask

	initial begin
		int len;
		clk = 1'b0;
		reset = 1'b0;
		enable = 1'b0;
		sample_valid = 1'b0;
		samples = '0;
		integration_len = 16'd20;
		rng_state = 32'hdf687952;

		repeat (8) @(posedge clk);
		reset <= 1'b1;
		enable <= 1'b1;
		idle_cycles(10);

		// partial window is discarded so no burst yet
		drive_samples(10, 1'b0, 1'b1);
		drop_enable(2);
		idle_cycles(20);

		for (int n = 0; n < 8; n++) begin
			rng_state = xorshift(rng_state);
			len = 20 + int'(rng_state % 41);
			run_integration(len, 1'b0, 1'b1);
		end

		run_integration(30000, 1'b1, 1'b0); // every sum saturates
		run_integration(25, 1'b0, 1'b1);

		// enable drop in the middle of a window
		@(posedge clk);
		integration_len <= 16'd40;
		drive_samples(15, 1'b0, 1'b1);
		drop_enable(3);
		drive_samples(40, 1'b0, 1'b1);
		wait_for_burst();
		idle_cycles(5);

		if (UUT.prop_check.failed) begin
			$display("ERRORS FOUND");
			$fatal(1, "the bound checker flagged a wrong record");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

/* verification/correlator_properties.sv */
// bound checker for the correlator front end
// models the window sums and the expected record stream from the top-level ports
module correlator_properties (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic sample_valid,
	input corr_pkg::sample_frame_t samples,
	input logic [corr_pkg::len_width-1:0] integration_len,
	input logic record_valid,
	input corr_pkg::record_t record
);

	int count_sum [corr_pkg::num_inputs];
	logic [corr_pkg::num_inputs-1:0] count_sat;
	int corr_sum [corr_pkg::num_baselines];
	logic [corr_pkg::num_baselines-1:0] corr_sat;
	int next_count [corr_pkg::num_inputs];
	logic [corr_pkg::num_inputs-1:0] next_count_sat;
	int next_corr [corr_pkg::num_baselines];
	logic [corr_pkg::num_baselines-1:0] next_corr_sat;
	logic [corr_pkg::len_width-1:0] window_count;
	logic [corr_pkg::result_width-1:0] exp_value [corr_pkg::num_records];
	logic [corr_pkg::num_records-1:0] exp_overflow;
	logic [corr_pkg::frame_width-1:0] exp_frame;
	logic [corr_pkg::index_width-1:0] exp_index;
	int since_dump; // cycles after the final sample of a window
	int exp_slot;
	logic exp_valid;
	logic exp_is_baseline;
	logic dump;
	logic fail_valid = 1'b0;
	logic fail_value = 1'b0;
	logic fail_overflow = 1'b0;
	logic fail_tag = 1'b0;
	logic fail_frame = 1'b0;
	logic failed;

	assign failed = fail_valid | fail_value | fail_overflow | fail_tag | fail_frame;
	assign dump = enable && sample_valid && (window_count == integration_len - 1'b1);

	// sums as they would stand once this sample is added
	always_comb begin
		int total;
		for (int i = 0; i < corr_pkg::num_inputs; i++) begin
			total = count_sum[i] + int'(samples.lane[i]);
			next_count[i] = (total > int'(corr_pkg::max_count)) ? int'(corr_pkg::max_count) : total;
			next_count_sat[i] = count_sat[i] || (total > int'(corr_pkg::max_count));
		end
		for (int b = 0; b < corr_pkg::num_baselines; b++) begin
			total = corr_sum[b] + int'(samples.lane[corr_pkg::baseline_a[b]])
				* int'(samples.lane[corr_pkg::baseline_b[b]]);
			next_corr[b] = (total > int'(corr_pkg::max_count)) ? int'(corr_pkg::max_count) : total;
			next_corr_sat[b] = corr_sat[b] || (total > int'(corr_pkg::max_count));
		end
	end

	// burst occupies cycles 1..10 after the dump edge
	always_comb begin
		int tag;
		exp_valid = (since_dump >= 1) && (since_dump <= corr_pkg::num_records);
		exp_slot = exp_valid ? since_dump - 1 : 0;
		exp_is_baseline = (exp_slot >= corr_pkg::num_inputs);
		tag = exp_is_baseline ? exp_slot - corr_pkg::num_inputs : exp_slot;
		exp_index = tag[corr_pkg::index_width-1:0];
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			window_count <= '0;
			since_dump <= 2 * corr_pkg::num_records; // nothing pending
			exp_frame <= '0;
			count_sat <= '0;
			corr_sat <= '0;
			for (int i = 0; i < corr_pkg::num_inputs; i++) begin
				count_sum[i] <= 0;
			end
			for (int b = 0; b < corr_pkg::num_baselines; b++) begin
				corr_sum[b] <= 0;
			end
		end else begin
			if (since_dump < 2 * corr_pkg::num_records) begin
				since_dump <= since_dump + 1;
			end
			if (since_dump == corr_pkg::num_records) begin
				exp_frame <= exp_frame + 1'b1; // last record of the burst
			end
			if (!enable) begin
				window_count <= '0;
				count_sat <= '0;
				corr_sat <= '0;
				for (int i = 0; i < corr_pkg::num_inputs; i++) begin
					count_sum[i] <= 0;
				end
				for (int b = 0; b < corr_pkg::num_baselines; b++) begin
					corr_sum[b] <= 0;
				end
			end else if (dump) begin
				for (int i = 0; i < corr_pkg::num_inputs; i++) begin
					exp_value[i] <= next_count[i][corr_pkg::result_width-1:0];
					exp_overflow[i] <= next_count_sat[i];
					count_sum[i] <= 0;
				end
				for (int b = 0; b < corr_pkg::num_baselines; b++) begin
					exp_value[corr_pkg::num_inputs + b] <= next_corr[b][corr_pkg::result_width-1:0];
					exp_overflow[corr_pkg::num_inputs + b] <= next_corr_sat[b];
					corr_sum[b] <= 0;
				end
				count_sat <= '0;
				corr_sat <= '0;
				window_count <= '0;
				since_dump <= 0;
			end else if (sample_valid) begin
				count_sum <= next_count;
				count_sat <= next_count_sat;
				corr_sum <= next_corr;
				corr_sat <= next_corr_sat;
				window_count <= window_count + 1'b1;
			end
		end
	end

	check_valid: assert property (@(posedge clk) disable iff (!reset)
		record_valid == exp_valid)
	else begin
		$error("mismatch at %0t: record_valid expected %b actual %b",
			$time, $sampled(exp_valid), $sampled(record_valid));
		fail_valid = 1'b1;
	end

	check_value: assert property (@(posedge clk) disable iff (!reset)
		record_valid |-> record.value == exp_value[exp_slot])
	else begin
		$error("mismatch at %0t: record.value expected %0d actual %0d",
			$time, $sampled(exp_value[exp_slot]), $sampled(record.value));
		fail_value = 1'b1;
	end

	check_overflow: assert property (@(posedge clk) disable iff (!reset)
		record_valid |-> record.overflow == exp_overflow[exp_slot])
	else begin
		$error("mismatch at %0t: record.overflow expected %b actual %b",
			$time, $sampled(exp_overflow[exp_slot]), $sampled(record.overflow));
		fail_overflow = 1'b1;
	end

	check_tag: assert property (@(posedge clk) disable iff (!reset)
		record_valid |-> (record.is_baseline == exp_is_baseline) && (record.index == exp_index))
	else begin
		$error("mismatch at %0t: record.is_baseline/index expected %b/%0d actual %b/%0d",
			$time, $sampled(exp_is_baseline), $sampled(exp_index),
			$sampled(record.is_baseline), $sampled(record.index));
		fail_tag = 1'b1;
	end

	check_frame: assert property (@(posedge clk) disable iff (!reset)
		record_valid |-> record.frame == exp_frame)
	else begin
		$error("mismatch at %0t: record.frame expected %0d actual %0d",
			$time, $sampled(exp_frame), $sampled(record.frame));
		fail_frame = 1'b1;
	end

endmodule

bind correlator_top correlator_properties prop_check (
	.clk(clk),
	.reset(reset),
	.enable(enable),
	.sample_valid(sample_valid),
	.samples(samples),
	.integration_len(integration_len),
	.record_valid(record_valid),
	.record(record)
);

/* rtl/correlator_top.sv */
// correlator front end top level
// timer, four pulse counters, six baseline accumulators, readout sequencer
module correlator_top (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic sample_valid,
	input corr_pkg::sample_frame_t samples,
	input logic [corr_pkg::len_width-1:0] integration_len,
	output logic record_valid,
	output corr_pkg::record_t record
);

	logic last_sample;
	logic frame_ready;
	logic [corr_pkg::result_width-1:0] counts [corr_pkg::num_inputs];
	logic [corr_pkg::num_inputs-1:0] count_saturated;
	logic [corr_pkg::result_width-1:0] correlations [corr_pkg::num_baselines];
	logic [corr_pkg::num_baselines-1:0] correlation_saturated;

	integration_timer timer (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.sample_valid(sample_valid),
		.integration_len(integration_len),
		.last_sample(last_sample),
		.frame_ready(frame_ready)
	);

	for (genvar i = 0; i < corr_pkg::num_inputs; i++) begin : g_input
		pulse_counter counter (
			.clk(clk),
			.reset(reset),
			.enable(enable),
			.sample_valid(sample_valid),
			.sample(samples.lane[i]),
			.last_sample(last_sample),
			.result(counts[i]),
			.saturated(count_saturated[i])
		);
	end

	for (genvar b = 0; b < corr_pkg::num_baselines; b++) begin : g_baseline
		baseline_accumulator accumulator (
			.clk(clk),
			.reset(reset),
			.enable(enable),
			.sample_valid(sample_valid),
			.sample_a(samples.lane[corr_pkg::baseline_a[b]]),
			.sample_b(samples.lane[corr_pkg::baseline_b[b]]),
			.last_sample(last_sample),
			.result(correlations[b]),
			.saturated(correlation_saturated[b])
		);
	end

	readout_sequencer sequencer (
		.clk(clk),
		.reset(reset),
		.frame_ready(frame_ready),
		.counts(counts),
		.count_saturated(count_saturated),
		.correlations(correlations),
		.correlation_saturated(correlation_saturated),
		.record_valid(record_valid),
		.record(record)
	);

endmodule

/* rtl/readout_sequencer.sv */
// readout sequencer
// snapshots the ten results on frame_ready and emits one record per cycle
// counts for inputs 0..3 first, then baselines 0..5
module readout_sequencer (
	input logic clk,
	input logic reset,
	input logic frame_ready,
	input logic [corr_pkg::result_width-1:0] counts [corr_pkg::num_inputs],
	input logic [corr_pkg::num_inputs-1:0] count_saturated,
	input logic [corr_pkg::result_width-1:0] correlations [corr_pkg::num_baselines],
	input logic [corr_pkg::num_baselines-1:0] correlation_saturated,
	output logic record_valid,
	output corr_pkg::record_t record
);

	logic [corr_pkg::result_width-1:0] snap_value [corr_pkg::num_records];
	logic [corr_pkg::num_records-1:0] snap_overflow;
	logic [corr_pkg::index_width-1:0] record_index;
	logic [corr_pkg::frame_width-1:0] frame_number;
	logic is_baseline;

	// snapshot frees the accumulators for the next window
	always_ff @(posedge clk) begin
		if (frame_ready) begin
			for (int i = 0; i < corr_pkg::num_inputs; i++) begin
				snap_value[i] <= counts[i];
				snap_overflow[i] <= count_saturated[i];
			end
			for (int b = 0; b < corr_pkg::num_baselines; b++) begin
				snap_value[corr_pkg::num_inputs + b] <= correlations[b];
				snap_overflow[corr_pkg::num_inputs + b] <= correlation_saturated[b];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			record_valid <= 1'b0;
			record_index <= '0;
			frame_number <= '0;
		end else if (frame_ready) begin
			record_valid <= 1'b1; // burst starts next cycle
			record_index <= '0;
		end else if (record_valid) begin
			if (record_index == corr_pkg::last_record) begin
				record_valid <= 1'b0;
				record_index <= '0;
				frame_number <= frame_number + 1'b1; // wraps at 256
			end else begin
				record_index <= record_index + 1'b1;
			end
		end
	end

	assign is_baseline = (record_index >= corr_pkg::first_baseline);

	always_comb begin
		record.frame = frame_number;
		record.is_baseline = is_baseline;
		if (is_baseline) begin
			record.index = record_index - corr_pkg::first_baseline;
		end else begin
			record.index = record_index;
		end
		record.overflow = snap_overflow[record_index];
		record.value = snap_value[record_index];
	end

endmodule

/* rtl/baseline_accumulator.sv */
// lag-zero baseline accumulator
// saturating sum of sample products for one input pair
module baseline_accumulator (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic sample_valid,
	input logic [corr_pkg::sample_width-1:0] sample_a,
	input logic [corr_pkg::sample_width-1:0] sample_b,
	input logic last_sample,
	output logic [corr_pkg::result_width-1:0] result,
	output logic saturated
);

	logic [2*corr_pkg::sample_width-1:0] product;
	logic [corr_pkg::result_width-1:0] running_sum;
	logic running_sat;
	logic [corr_pkg::result_width:0] next_total;
	logic [corr_pkg::result_width-1:0] next_sum;
	logic next_sat;
	logic accept;

	assign accept = sample_valid & enable;
	assign product = sample_a * sample_b; // at most 9

	always_comb begin
		next_total = {1'b0, running_sum}
			+ {{(corr_pkg::result_width + 1 - 2*corr_pkg::sample_width){1'b0}}, product};
		if (next_total[corr_pkg::result_width]) begin
			next_sum = corr_pkg::max_count;
			next_sat = 1'b1;
		end else begin
			next_sum = next_total[corr_pkg::result_width-1:0];
			next_sat = running_sat; // sticky until the dump
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			running_sum <= '0;
			running_sat <= 1'b0;
		end else if (!enable || last_sample) begin
			running_sum <= '0;
			running_sat <= 1'b0;
		end else if (accept) begin
			running_sum <= next_sum;
			running_sat <= next_sat;
		end
	end

	always_ff @(posedge clk) begin
		if (last_sample) begin
			result <= next_sum;
			saturated <= next_sat;
		end
	end

endmodule

/* rtl/pulse_counter.sv */
// per-input pulse counter
// saturating sum of sample values dumped at the end of each window
module pulse_counter (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic sample_valid,
	input logic [corr_pkg::sample_width-1:0] sample,
	input logic last_sample,
	output logic [corr_pkg::result_width-1:0] result,
	output logic saturated
);

	logic [corr_pkg::result_width-1:0] running_sum;
	logic running_sat;
	logic [corr_pkg::result_width:0] next_total; // carry bit catches overflow
	logic [corr_pkg::result_width-1:0] next_sum;
	logic next_sat;
	logic accept;

	assign accept = sample_valid & enable;

	always_comb begin
		next_total = {1'b0, running_sum}
			+ {{(corr_pkg::result_width + 1 - corr_pkg::sample_width){1'b0}}, sample};
		if (next_total[corr_pkg::result_width]) begin
			next_sum = corr_pkg::max_count; // hold at the top
			next_sat = 1'b1;
		end else begin
			next_sum = next_total[corr_pkg::result_width-1:0];
			next_sat = running_sat;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			running_sum <= '0;
			running_sat <= 1'b0;
		end else if (!enable || last_sample) begin
			running_sum <= '0;
			running_sat <= 1'b0;
		end else if (accept) begin
			running_sum <= next_sum;
			running_sat <= next_sat;
		end
	end

	// total including the final sample
	always_ff @(posedge clk) begin
		if (last_sample) begin
			result <= next_sum;
			saturated <= next_sat;
		end
	end

endmodule

/* rtl/integration_timer.sv */
// integration timer
// counts accepted samples, flags the last one of each window
module integration_timer (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic sample_valid,
	input logic [corr_pkg::len_width-1:0] integration_len,
	output logic last_sample,
	output logic frame_ready
);

	logic [corr_pkg::len_width-1:0] sample_count;
	logic [corr_pkg::len_width-1:0] last_index;
	logic accept;

	assign accept = sample_valid & enable;
	assign last_index = integration_len - 1'b1;

	// same cycle as the strobe carrying the final sample
	assign last_sample = accept && (sample_count == last_index);

	always_ff @(posedge clk) begin
		if (!reset) begin
			sample_count <= '0;
			frame_ready <= 1'b0;
		end else begin
			frame_ready <= last_sample; // results valid from here
			if (!enable) begin
				sample_count <= '0; // partial window dropped
			end else if (last_sample) begin
				sample_count <= '0;
			end else if (accept) begin
				sample_count <= sample_count + 1'b1;
			end
		end
	end

endmodule

/* rtl/corr_pkg.sv */
// sizes and saturation limit for the correlator front end
// sample frame and output record structs
// input pair order of the six baselines
package corr_pkg;

	localparam int num_inputs = 4;
	localparam int sample_width = 2; // unsigned samples
	localparam int num_baselines = num_inputs * (num_inputs - 1) / 2;
	localparam int result_width = 16;
	localparam int len_width = 16;
	localparam int frame_width = 8;
	localparam int index_width = 4;
	localparam int num_records = num_inputs + num_baselines;

	localparam logic [result_width-1:0] max_count = '1;

	// counts come first in the record index, then baselines
	localparam logic [index_width-1:0] first_baseline = index_width'(num_inputs);
	localparam logic [index_width-1:0] last_record = index_width'(num_records - 1);

	// baseline pairs in order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	localparam int baseline_a [num_baselines] = '{0, 0, 0, 1, 1, 2};
	localparam int baseline_b [num_baselines] = '{1, 2, 3, 2, 3, 3};

	typedef struct packed {
		logic [num_inputs-1:0][sample_width-1:0] lane; // lane[i] is input i
	} sample_frame_t;

	typedef struct packed {
		logic [frame_width-1:0] frame;
		logic is_baseline;
		logic [index_width-1:0] index; // input or baseline number
		logic overflow;
		logic [result_width-1:0] value;
	} record_t;

endpackage
